//--- flist.f
design/align_pkg.sv
design/pe_cell.sv
design/pe_array.sv
design/max_tree.sv
design/align_ctrl.sv
design/align_top.sv
verification/align_sva.sv
verification/tb_align.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_align -f flist.f -o sim_align \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_align > sim.log 2>&1 || echo "Test failed" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

//--- verification/tb_align.sv
`timescale 1ns/1ps
`default_nettype none

module tb_align;

    logic                      i_clk;
    logic                      i_rst;
    logic                      i_ref_valid;
    logic                      o_ref_ready;
    align_pkg::ref_seg_t       i_ref;
    logic                      i_query_valid;
    logic                      o_query_ready;
    align_pkg::query_beat_t    i_query;
    logic                      o_result_valid;
    logic                      i_result_ready;
    align_pkg::align_result_t  o_result;

    align_pkg::base_t          query_mem [0:63];
    align_pkg::align_result_t  exp_q [$];
    int                        launched;
    int                        checked;

    align_top uut (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_ref_valid   (i_ref_valid),
        .o_ref_ready   (o_ref_ready),
        .i_ref         (i_ref),
        .i_query_valid (i_query_valid),
        .o_query_ready (o_query_ready),
        .i_query       (i_query),
        .o_result_valid(o_result_valid),
        .i_result_ready(i_result_ready),
        .o_result      (o_result)
    );

    always #50 i_clk = ~i_clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_score(input string name, input align_pkg::score_t got,
                               input align_pkg::score_t exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_result(input string name, input align_pkg::align_result_t got,
                                input align_pkg::align_result_t exp);
        check_score({name, ".max_score"}, got.max_score, exp.max_score);
        check_score({name, ".final_score"}, got.final_score, exp.final_score);
    endtask

    function automatic int larger(input int a, input int b);
        return (a > b) ? a : b;
    endfunction

    // full affine-gap matrix, rows are reference bases, columns query bases
    function automatic align_pkg::align_result_t expected_result(
        input align_pkg::ref_seg_t seg, input int len);
        int h [0:align_pkg::NUM_PE][0:64];
        int e [0:align_pkg::NUM_PE][0:64];
        int f [0:align_pkg::NUM_PE][0:64];
        int i;
        int j;
        int s;
        int best;
        align_pkg::align_result_t res;
        best = int'(align_pkg::NEG_INF);
        for (i = 0; i <= align_pkg::NUM_PE; i++) begin
            for (j = 0; j <= len; j++) begin
                e[i][j] = int'(align_pkg::NEG_INF);
                f[i][j] = int'(align_pkg::NEG_INF);
                if (i == 0 && j == 0) begin
                    h[i][j] = 0;
                end else if (i == 0) begin
                    h[i][j] = int'(align_pkg::GAP_OPEN) + int'(align_pkg::GAP_EXT) * (j - 1);
                end else if (j == 0) begin
                    h[i][j] = int'(align_pkg::GAP_OPEN) + int'(align_pkg::GAP_EXT) * (i - 1);
                end else begin
                    s = (query_mem[j-1] == seg[i-1]) ? int'(align_pkg::MATCH_SCORE)
                                                     : int'(align_pkg::MISMATCH_SCORE);
                    e[i][j] = larger(h[i][j-1] + int'(align_pkg::GAP_OPEN),
                                     e[i][j-1] + int'(align_pkg::GAP_EXT));
                    f[i][j] = larger(h[i-1][j] + int'(align_pkg::GAP_OPEN),
                                     f[i-1][j] + int'(align_pkg::GAP_EXT));
                    h[i][j] = larger(h[i-1][j-1] + s, larger(e[i][j], f[i][j]));
                    best = larger(best, h[i][j]);
                end
            end
        end
        res.max_score   = align_pkg::score_t'(best);
        res.final_score = align_pkg::score_t'(h[align_pkg::NUM_PE][len]);
        return res;
    endfunction

    function automatic align_pkg::ref_seg_t random_segment();
        align_pkg::ref_seg_t seg;
        for (int k = 0; k < align_pkg::NUM_PE; k++) begin
            seg[k] = align_pkg::base_t'($urandom_range(3, 0));
        end
        return seg;
    endfunction

    task automatic fill_query(input int len);
        for (int j = 0; j < len; j++) begin
            query_mem[j] = align_pkg::base_t'($urandom_range(3, 0));
        end
    endtask

    task automatic tick_or_timeout(inout int cnt, input string what);
        @(negedge i_clk);
        cnt++;
        if (cnt > 1000) begin
            fail_run({"timeout: ", what});
        end
    endtask

    // one job: reference, query with optional bubbles, result with optional stall
    task automatic run_job(input align_pkg::ref_seg_t seg, input int len,
                           input int gap_max, input int hold_max);
        int cnt;
        int j;
        int hold;
        align_pkg::align_result_t held;
        exp_q.push_back(expected_result(seg, len));
        launched++;
        cnt = 0;
        i_ref = seg;
        i_ref_valid = 1'b1;
        while (!o_ref_ready) begin
            tick_or_timeout(cnt, "reference segment was never accepted");
        end
        @(negedge i_clk);
        i_ref_valid = 1'b0;
        for (j = 0; j < len; j++) begin
            if (gap_max > 0) begin
                repeat ($urandom_range(gap_max, 0)) @(negedge i_clk);
            end
            cnt = 0;
            i_query.base = query_mem[j];
            i_query.last = (j == len - 1);
            i_query_valid = 1'b1;
            while (!o_query_ready) begin
                tick_or_timeout(cnt, "query beat was never accepted");
            end
            @(negedge i_clk);
            i_query_valid = 1'b0;
        end
        cnt = 0;
        while (!o_result_valid) begin
            tick_or_timeout(cnt, "no result came out after the last query beat");
        end
        hold = (hold_max > 0) ? $urandom_range(hold_max, 1) : 0;
        held = o_result;
        repeat (hold) begin
            @(negedge i_clk);
            check_bit("o_result_valid", o_result_valid, 1'b1);
            check_bit("o_ref_ready", o_ref_ready, 1'b0);
            check_result("o_result", o_result, held);
        end
        i_result_ready = 1'b1;
        @(negedge i_clk);
        i_result_ready = 1'b0;
    endtask

    // compare each accepted result against the oldest outstanding job
    always @(posedge i_clk) begin
        if (!i_rst && o_result_valid && i_result_ready) begin
            if (exp_q.size() == 0) begin
                fail_run("a result was accepted with no job outstanding");
            end else begin
                check_result("o_result", o_result, exp_q.pop_front());
                checked++;
            end
        end
    end

    initial begin
        int n;
        int len;
        align_pkg::ref_seg_t seg;
        align_pkg::align_result_t exp;
        void'($urandom(87943));
        i_clk = 1'b0;
        i_rst = 1'b1;
        i_ref_valid = 1'b0;
        i_ref = '0;
        i_query_valid = 1'b0;
        i_query = '0;
        i_result_ready = 1'b0;
        launched = 0;
        checked = 0;
        repeat (5) @(negedge i_clk);
        i_rst = 1'b0;

        check_bit("o_result_valid", o_result_valid, 1'b0);
        check_bit("o_query_ready", o_query_ready, 1'b0);
        check_bit("o_ref_ready", o_ref_ready, 1'b1);
        fill_query(1);
        run_job(random_segment(), 1, 0, 0);

        // query identical to the reference
        seg = random_segment();
        for (n = 0; n < align_pkg::NUM_PE; n++) begin
            query_mem[n] = seg[n];
        end
        exp = expected_result(seg, align_pkg::NUM_PE);
        check_score("expected max_score", exp.max_score, align_pkg::score_t'(32));
        check_score("expected final_score", exp.final_score, align_pkg::score_t'(32));
        run_job(seg, align_pkg::NUM_PE, 0, 0);

        for (n = 0; n < 20; n++) begin
            len = $urandom_range(64, 1);
            fill_query(len);
            run_job(random_segment(), len, 0, 0);
        end
        for (n = 0; n < 8; n++) begin
            len = $urandom_range(64, 1);
            fill_query(len);
            run_job(random_segment(), len, 3, 0);
        end
        for (n = 0; n < 4; n++) begin
            len = $urandom_range(40, 1);
            fill_query(len);
            run_job(random_segment(), len, 0, 8);
        end

        // same query, new segment each time, no idle cycles between jobs
        fill_query(24);
        for (n = 0; n < 4; n++) begin
            run_job(random_segment(), 24, 0, 0);
        end

        if (checked != launched || exp_q.size() != 0) begin
            fail_run("not every job returned a result");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verification/align_sva.sv
`timescale 1ns/1ps
`default_nettype none

module align_sva (
    input logic                      i_clk,
    input logic                      i_rst,
    input logic                      o_ref_ready,
    input logic                      o_query_ready,
    input logic                      o_result_valid,
    input logic                      i_result_ready,
    input align_pkg::align_result_t  o_result
);

    // reference and query streams never open together
    ready_exclusive: assert property (@(posedge i_clk) disable iff (i_rst)
        !(o_ref_ready && o_query_ready))
        else $error("reference and query ready high together");

    // a stalled result holds its value
    result_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_result_valid && !i_result_ready) |=> (o_result_valid && $stable(o_result)))
        else $error("result changed or dropped while stalled");

    reset_quiet: assert property (@(posedge i_clk)
        $fell(i_rst) |-> !o_result_valid)
        else $error("result valid in the cycle after reset release");

endmodule

bind align_top align_sva u_sva (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .o_ref_ready   (o_ref_ready),
    .o_query_ready (o_query_ready),
    .o_result_valid(o_result_valid),
    .i_result_ready(i_result_ready),
    .o_result      (o_result)
);

`default_nettype wire

//--- design/align_top.sv
`timescale 1ns/1ps
`default_nettype none

module align_top (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_ref_valid,
    output logic                        o_ref_ready,
    input  align_pkg::ref_seg_t         i_ref,
    input  logic                        i_query_valid,
    output logic                        o_query_ready,
    input  align_pkg::query_beat_t      i_query,
    output logic                        o_result_valid,
    input  logic                        i_result_ready,
    output align_pkg::align_result_t    o_result
);

    logic                                       start;
    align_pkg::query_beat_t                     beat;
    logic                                       beat_valid;
    align_pkg::score_t [align_pkg::NUM_PE-1:0]  h_scores;
    logic [align_pkg::NUM_PE-1:0]               active;
    align_pkg::pe_link_t                        tail;
    align_pkg::score_t                          tree_max;
    logic                                       tree_max_valid;

    align_ctrl u_ctrl (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_ref_valid   (i_ref_valid),
        .o_ref_ready   (o_ref_ready),
        .i_query_valid (i_query_valid),
        .o_query_ready (o_query_ready),
        .i_query       (i_query),
        .o_start       (start),
        .o_beat        (beat),
        .o_beat_valid  (beat_valid),
        .i_tail        (tail),
        .i_max         (tree_max),
        .i_max_valid   (tree_max_valid),
        .o_result_valid(o_result_valid),
        .i_result_ready(i_result_ready),
        .o_result      (o_result)
    );

    pe_array u_array (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_start     (start),
        .i_ref       (i_ref),
        .i_beat      (beat),
        .i_beat_valid(beat_valid),
        .o_h_scores  (h_scores),
        .o_active    (active),
        .o_tail      (tail)
    );

    max_tree u_tree (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_scores   (h_scores),
        .i_active   (active),
        .o_max      (tree_max),
        .o_max_valid(tree_max_valid)
    );

endmodule

`default_nettype wire

//--- design/align_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module align_ctrl (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_ref_valid,
    output logic                        o_ref_ready,
    input  logic                        i_query_valid,
    output logic                        o_query_ready,
    input  align_pkg::query_beat_t      i_query,
    output logic                        o_start,
    output align_pkg::query_beat_t      o_beat,
    output logic                        o_beat_valid,
    input  align_pkg::pe_link_t         i_tail,
    input  align_pkg::score_t           i_max,
    input  logic                        i_max_valid,
    output logic                        o_result_valid,
    input  logic                        i_result_ready,
    output align_pkg::align_result_t    o_result
);

    align_pkg::ctrl_state_e       state;
    align_pkg::ctrl_state_e       state_next;

    logic [align_pkg::COL_W-1:0]  col_cnt;
    logic                         tail_last;
    logic                         tail_last_q;
    align_pkg::score_t            run_max;
    align_pkg::score_t            max_next;
    align_pkg::score_t            final_q;
    align_pkg::align_result_t     result_q;

    assign o_ref_ready    = (state == align_pkg::IDLE);
    assign o_query_ready  = (state == align_pkg::FILL);
    assign o_result_valid = (state == align_pkg::DONE);
    assign o_start        = i_ref_valid & o_ref_ready;
    assign o_beat_valid   = i_query_valid & o_query_ready;
    assign tail_last      = i_tail.valid & i_tail.last;

    // longest query ends here even without its last flag
    always_comb begin
        o_beat = i_query;
        if (col_cnt == align_pkg::LAST_COL) begin
            o_beat.last = 1'b1;
        end
    end

    assign max_next = (i_max_valid && i_max > run_max) ? i_max : run_max;

    always_comb begin
        state_next = state;
        case (state)
            align_pkg::IDLE: begin
                if (o_start) begin
                    state_next = align_pkg::FILL;
                end
            end
            align_pkg::FILL: begin
                if (o_beat_valid && o_beat.last) begin
                    state_next = align_pkg::DRAIN;
                end
            end
            align_pkg::DRAIN: begin
                // tree output of the last column arrives now
                if (tail_last_q) begin
                    state_next = align_pkg::DONE;
                end
            end
            default: begin
                if (i_result_ready) begin
                    state_next = align_pkg::IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state       <= align_pkg::IDLE;
            col_cnt     <= '0;
            tail_last_q <= 1'b0;
        end else begin
            state       <= state_next;
            tail_last_q <= tail_last;
            if (o_start) begin
                col_cnt <= '0;
            end else if (o_beat_valid) begin
                col_cnt <= col_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_start) begin
            run_max <= align_pkg::NEG_INF;
        end else begin
            run_max <= max_next;
        end
        if (tail_last) begin
            final_q <= i_tail.h;
        end
        if (state == align_pkg::DRAIN && tail_last_q) begin
            result_q.max_score   <= max_next;
            result_q.final_score <= final_q;
        end
    end

    assign o_result = result_q;

endmodule

`default_nettype wire

//--- design/max_tree.sv
`timescale 1ns/1ps
`default_nettype none

module max_tree (
    input  logic                                        i_clk,
    input  logic                                        i_rst,
    input  align_pkg::score_t [align_pkg::NUM_PE-1:0]   i_scores,
    input  logic [align_pkg::NUM_PE-1:0]                i_active,
    output align_pkg::score_t                           o_max,
    output logic                                        o_max_valid
);

    // heap of compare nodes with the leaves in the upper half and the root at 0
    align_pkg::score_t node [0:2*align_pkg::NUM_PE-2];

    always_comb begin
        // inactive lanes drop out as NEG_INF
        for (int i = 0; i < align_pkg::NUM_PE; i++) begin
            node[align_pkg::NUM_PE-1+i] = i_active[i] ? i_scores[i] : align_pkg::NEG_INF;
        end
        for (int i = align_pkg::NUM_PE - 2; i >= 0; i--) begin
            node[i] = (node[2*i+1] > node[2*i+2]) ? node[2*i+1] : node[2*i+2];
        end
    end

    always_ff @(posedge i_clk) begin
        o_max <= node[0];
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_max_valid <= 1'b0;
        end else begin
            o_max_valid <= |i_active;
        end
    end

endmodule

`default_nettype wire

//--- design/pe_array.sv
`timescale 1ns/1ps
`default_nettype none

module pe_array (
    input  logic                                        i_clk,
    input  logic                                        i_rst,
    input  logic                                        i_start,
    input  align_pkg::ref_seg_t                         i_ref,
    input  align_pkg::query_beat_t                      i_beat,
    input  logic                                        i_beat_valid,
    output align_pkg::score_t [align_pkg::NUM_PE-1:0]   o_h_scores,
    output logic [align_pkg::NUM_PE-1:0]                o_active,
    output align_pkg::pe_link_t                         o_tail
);

    align_pkg::ref_seg_t ref_q;

    // H(0,j) for the column entering PE 0
    align_pkg::score_t   top_h;

    // link[k] enters PE k, link[k+1] leaves it
    align_pkg::pe_link_t link [0:align_pkg::NUM_PE];

    always_ff @(posedge i_clk) begin
        if (i_start) begin
            ref_q <= i_ref;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_start) begin
            top_h <= align_pkg::GAP_OPEN;
        end else if (i_beat_valid) begin
            top_h <= top_h + align_pkg::GAP_EXT;
        end
    end

    // head of chain, bubbles enter with valid clear
    always_comb begin
        link[0].valid = i_beat_valid;
        link[0].last  = i_beat.last;
        link[0].base  = i_beat.base;
        link[0].h     = top_h;
        link[0].f     = align_pkg::NEG_INF;
    end

    genvar k;
    generate
        for (k = 0; k < align_pkg::NUM_PE; k++) begin : g_pe
            pe_cell #(
                .ROW(k + 1)
            ) u_pe (
                .i_clk     (i_clk),
                .i_rst     (i_rst),
                .i_start   (i_start),
                .i_ref_base(ref_q[k]),
                .i_link    (link[k]),
                .o_link    (link[k+1])
            );

            assign o_h_scores[k] = link[k+1].h;
            assign o_active[k]   = link[k+1].valid;
        end
    endgenerate

    assign o_tail = link[align_pkg::NUM_PE];

endmodule

`default_nettype wire

//--- design/pe_cell.sv
`timescale 1ns/1ps
`default_nettype none

module pe_cell #(
    parameter int ROW = 1
) (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_start,
    input  align_pkg::base_t     i_ref_base,
    input  align_pkg::pe_link_t  i_link,
    output align_pkg::pe_link_t  o_link
);

    // row state: H and E of the left cell, H of the diagonal cell
    align_pkg::score_t left_h;
    align_pkg::score_t left_e;
    align_pkg::score_t diag_h;

    align_pkg::score_t sub;
    align_pkg::score_t e_new;
    align_pkg::score_t f_new;
    align_pkg::score_t h_diag;
    align_pkg::score_t h_new;

    logic              valid_q;
    logic              last_q;
    align_pkg::base_t  base_q;
    align_pkg::score_t h_q;
    align_pkg::score_t f_q;

    always_comb begin
        sub = (i_link.base == i_ref_base) ? align_pkg::MATCH_SCORE
                                          : align_pkg::MISMATCH_SCORE;
        e_new = left_h + align_pkg::GAP_OPEN;
        if (left_e + align_pkg::GAP_EXT > e_new) begin
            e_new = left_e + align_pkg::GAP_EXT;
        end
        f_new = i_link.h + align_pkg::GAP_OPEN;
        if (i_link.f + align_pkg::GAP_EXT > f_new) begin
            f_new = i_link.f + align_pkg::GAP_EXT;
        end
        h_diag = diag_h + sub;
        h_new  = (h_diag > e_new) ? h_diag : e_new;
        if (f_new > h_new) begin
            h_new = f_new;
        end
    end

    // bubbles leave the row untouched
    always_ff @(posedge i_clk) begin
        if (i_start) begin
            left_h <= align_pkg::gap_score(ROW);
            left_e <= align_pkg::NEG_INF;
            diag_h <= align_pkg::gap_score(ROW - 1);
        end else if (i_link.valid) begin
            left_h <= h_new;
            left_e <= e_new;
            diag_h <= i_link.h;
            last_q <= i_link.last;
            base_q <= i_link.base;
            h_q    <= h_new;
            f_q    <= f_new;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_link.valid;
        end
    end

    assign o_link = '{valid: valid_q, last: last_q, base: base_q, h: h_q, f: f_q};

endmodule

`default_nettype wire

//--- design/align_pkg.sv
`default_nettype none

package align_pkg;

    localparam int NUM_PE  = 16;
    localparam int BASE_W  = 2;
    localparam int SCORE_W = 14;
    localparam int COL_W   = 10;

    // query beats counted before the longest allowed beat
    localparam logic [COL_W-1:0] LAST_COL = {{(COL_W-1){1'b1}}, 1'b0};

    typedef logic [BASE_W-1:0] base_t;
    typedef logic signed [SCORE_W-1:0] score_t;

    localparam score_t MATCH_SCORE    = 14'sd2;
    localparam score_t MISMATCH_SCORE = -14'sd3;
    localparam score_t GAP_OPEN       = -14'sd12;
    localparam score_t GAP_EXT        = -14'sd1;
    localparam score_t NEG_INF        = -14'sd4096;

    // element k belongs to row k+1
    typedef base_t [NUM_PE-1:0] ref_seg_t;

    typedef struct packed {
        logic  last;
        base_t base;
    } query_beat_t;

    typedef struct packed {
        logic   valid;
        logic   last;
        base_t  base;
        score_t h;
        score_t f;
    } pe_link_t;

    typedef struct packed {
        score_t max_score;
        score_t final_score;
    } align_result_t;

    typedef enum logic [1:0] {
        IDLE,
        FILL,
        DRAIN,
        DONE
    } ctrl_state_e;

    // boundary H for row or column k
    function automatic score_t gap_score(input int k);
        if (k == 0) begin
            return '0;
        end
        return score_t'(int'(GAP_OPEN) + int'(GAP_EXT) * (k - 1));
    endfunction

endpackage

`default_nettype wire
